// File: norm_round_config.svh
// Build-time configuration of the FP32 normalize and round unit
// Lane count, credit counts and FP32 field widths

`ifndef NORM_ROUND_CONFIG_SVH
`define NORM_ROUND_CONFIG_SVH

// Parallel lanes, served round-robin
`define NR_LANES 2

// Result FIFO depth, also the upstream credit count
`define NR_IN_CREDITS 4

// Downstream credits held after reset
`define NR_OUT_CREDITS 2

// FP32 biased exponent field
`define NR_EXP_W 8

// FP32 fraction, hidden bit not counted
`define NR_MANT_W 23

`endif

// File: norm_round_pkg.sv
// Shared types of the FP32 normalize and round unit
// Operand and result vectors, rounding modes, lane FSM states, constants

`include "norm_round_config.svh"

package norm_round_pkg;

  // Hidden bit, fraction and 4 rounding bits; MSB has weight 1
  typedef logic [`NR_MANT_W+4:0]              mant_in_t;
  typedef logic signed [`NR_EXP_W+1:0]        exp_in_t;     // Biased, may go negative
  typedef logic [`NR_MANT_W:0]                mant_norm_t;  // Hidden bit included
  typedef logic [1:0]                         round_ext_t;  // {guard, sticky}
  typedef logic [`NR_EXP_W-1:0]               exp_field_t;
  typedef logic [`NR_EXP_W+`NR_MANT_W:0]      fp32_t;
  typedef logic [4:0]                         fflags_t;     // {NV, DZ, OF, UF, NX}
  typedef logic [$clog2(`NR_LANES)-1:0]       lane_idx_t;

  // Bit positions in fflags_t
  localparam int FL_NV = 4;
  localparam int FL_DZ = 3;
  localparam int FL_OF = 2;
  localparam int FL_UF = 1;
  localparam int FL_NX = 0;

  typedef enum logic [1:0]
  {
    RM_NEAREST  = 2'd0,  // Nearest, ties to even
    RM_TRUNC    = 2'd1,  // Toward zero
    RM_PLUSINF  = 2'd2,
    RM_MINUSINF = 2'd3
  } round_mode_e;

  typedef enum logic [1:0]
  {
    ST_IDLE,
    ST_NORM,   // Normalized operand held, rounding under way
    ST_ROUND   // Rounded result held, done raised
  } lane_state_e;

  typedef enum logic {OP_DIV, OP_SQRT} op_kind_e;

  localparam fp32_t C_QNAN_FP32 = 32'h7fc0_0000;  // Canonical quiet NaN

endpackage

// File: norm_round_dispatch.sv
// Operation dispatcher
// Registers each accepted operation and starts the lane under a
// round-robin pointer; tracks upstream credits for checking

`timescale 1ns/100ps

`include "norm_round_config.svh"

module norm_round_dispatch
(
  input  logic                         clk,
  input  logic                         reset,
  input  logic                         in_valid,
  input  norm_round_pkg::mant_in_t     mant_in,
  input  norm_round_pkg::exp_in_t      exp_in,
  input  logic                         sign_in,
  input  norm_round_pkg::op_kind_e     op,
  input  logic                         inf_a,
  input  logic                         inf_b,
  input  logic                         zero_a,
  input  logic                         zero_b,
  input  logic                         nan_a,
  input  logic                         nan_b,
  input  logic                         snan,
  input  norm_round_pkg::round_mode_e  rm,
  input  logic                         in_credit,
  output logic [`NR_LANES-1:0]         lane_start,
  output norm_round_pkg::mant_in_t     op_mant,
  output norm_round_pkg::exp_in_t      op_exp,
  output logic                         op_sign,
  output norm_round_pkg::op_kind_e     op_kind,
  output logic [6:0]                   op_special,  // {inf_a, inf_b, zero_a, zero_b, nan_a, nan_b, snan}
  output norm_round_pkg::round_mode_e  op_rm
);
  import norm_round_pkg::*;

  localparam int LANES = `NR_LANES;
  localparam int ICW   = $clog2(`NR_IN_CREDITS + 1);

  lane_idx_t      ptr;      // Next lane to start
  logic [ICW-1:0] credits;  // Mirror of the upstream credit count

  // Operation fields, shared by all lanes
  always_ff @(posedge clk)
  begin
    if (in_valid)
    begin
      op_mant    <= mant_in;
      op_exp     <= exp_in;
      op_sign    <= sign_in;
      op_kind    <= op;
      op_special <= {inf_a, inf_b, zero_a, zero_b, nan_a, nan_b, snan};
      op_rm      <= rm;
    end
  end

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      lane_start <= '0;
      ptr        <= '0;
      credits    <= ICW'(`NR_IN_CREDITS);
    end
    else
    begin
      lane_start <= in_valid ? (LANES'(1) << ptr) : '0;  // One-hot, one cycle
      if (in_valid)
        ptr <= (ptr == lane_idx_t'(LANES - 1)) ? '0 : ptr + 1'b1;
      credits <= credits - ICW'(in_valid) + ICW'(in_credit);
    end
  end

  // Upstream may only send while it still holds a credit
  a_credit_held: assert property (@(posedge clk) disable iff (reset)
    in_valid |-> credits != '0)
    else $error("in_valid without upstream credit");

endmodule

// File: fp_normalize.sv
// FP32 normalizer
// Resolves NaN, infinity, zero, divide-by-zero and negative square root,
// otherwise brings the mantissa to [1, 2) and shifts a too-small
// exponent down into a denormal, keeping guard and sticky for rounding

`timescale 1ns/100ps

`include "norm_round_config.svh"

module fp_normalize
(
  input  norm_round_pkg::mant_in_t    op_mant,
  input  norm_round_pkg::exp_in_t     op_exp,
  input  logic                        op_sign,
  input  norm_round_pkg::op_kind_e    op_kind,
  input  logic [6:0]                  op_special,
  output norm_round_pkg::mant_norm_t  norm_mant,
  output norm_round_pkg::round_ext_t  norm_ext,
  output norm_round_pkg::exp_field_t  norm_exp,
  output logic                        norm_sign,
  output logic                        special_hit,
  output norm_round_pkg::fp32_t       special_result,
  output norm_round_pkg::fflags_t     pre_fflags
);
  import norm_round_pkg::*;

  localparam int IN_W  = $bits(mant_in_t);
  localparam int MN_W  = $bits(mant_norm_t);
  localparam int PAD_W = `NR_MANT_W + 3;            // Longest shift that still keeps sticky
  localparam int WIN_W = IN_W + PAD_W;
  localparam int SHW   = $clog2(PAD_W + 1);
  localparam exp_in_t EXP_INF = exp_in_t'((1 << `NR_EXP_W) - 1);

  logic inf_a, inf_b, zero_a, zero_b, nan_a, nan_b, snan;
  logic is_div;
  logic is_sqrt;
  logic m_top;                       // Mantissa already >= 1
  mant_in_t m_norm;
  exp_in_t  e_norm;
  logic     denorm;
  logic [$bits(exp_in_t)-1:0] sh_raw;
  logic [SHW-1:0]   sh_amt;
  logic [WIN_W-1:0] win;             // Mantissa with room for the shifted-out bits
  fp32_t inf_res;
  fp32_t zero_res;

  assign {inf_a, inf_b, zero_a, zero_b, nan_a, nan_b, snan} = op_special;
  assign is_div  = (op_kind == OP_DIV);
  assign is_sqrt = (op_kind == OP_SQRT);

  //////////////////////////////////////////////////////////////////////
  // Normalization
  //////////////////////////////////////////////////////////////////////

  assign m_top  = op_mant[IN_W-1];
  assign m_norm = m_top ? op_mant : op_mant << 1;            // 0.1xx -> 1.xx
  assign e_norm = m_top ? op_exp : op_exp - exp_in_t'(1);
  assign denorm = (e_norm <= exp_in_t'(0));

  // Right shift of 1 - exp for denormals, clamped once all bits are sticky
  assign sh_raw = exp_in_t'(1) - e_norm;
  assign sh_amt = !denorm ? '0
                : (sh_raw > PAD_W) ? SHW'(PAD_W)
                : sh_raw[SHW-1:0];
  assign win    = {m_norm, {PAD_W{1'b0}}} >> sh_amt;

  assign norm_mant = win[WIN_W-1 -: MN_W];
  assign norm_ext  = {win[WIN_W-1-MN_W], |win[WIN_W-2-MN_W:0]};  // Guard, sticky
  assign norm_exp  = denorm ? '0 : e_norm[`NR_EXP_W-1:0];
  assign norm_sign = op_sign;

  //////////////////////////////////////////////////////////////////////
  // Special cases, highest priority first
  //////////////////////////////////////////////////////////////////////

  assign inf_res  = {op_sign, {`NR_EXP_W{1'b1}}, {`NR_MANT_W{1'b0}}};
  assign zero_res = {op_sign, {(`NR_EXP_W + `NR_MANT_W){1'b0}}};

  always_comb
  begin
    special_hit    = 1'b1;
    special_result = C_QNAN_FP32;   // Default for every invalid case
    pre_fflags     = '0;
    if (nan_a || nan_b)
      pre_fflags[FL_NV] = snan;     // Only a signalling NaN is invalid
    else if (inf_a)
    begin
      if ((is_div && inf_b) || (is_sqrt && op_sign))
        pre_fflags[FL_NV] = 1'b1;   // inf/inf, sqrt(-inf)
      else
        special_result = inf_res;
    end
    else if (is_div && inf_b)
      special_result = zero_res;    // x/inf
    else if (zero_a)
    begin
      if (is_div && zero_b)
        pre_fflags[FL_NV] = 1'b1;   // 0/0
      else
        special_result = zero_res;
    end
    else if (is_div && zero_b)
    begin
      special_result    = inf_res;  // x/0
      pre_fflags[FL_DZ] = 1'b1;
    end
    else if (is_sqrt && op_sign)
      pre_fflags[FL_NV] = 1'b1;     // sqrt of a negative number
    else if (op_mant == '0)
      special_result = zero_res;
    else if (e_norm >= EXP_INF)
    begin
      special_result    = inf_res;  // Overflow before rounding
      pre_fflags[FL_OF] = 1'b1;
      pre_fflags[FL_NX] = 1'b1;
    end
    else
      special_hit = 1'b0;
  end

endmodule

// File: fp_round.sv
// FP32 rounder and packer
// Applies the rounding mode, renormalizes on carry, turns exponent 255
// into infinity, and raises OF, UF and NX; special results pass through

`timescale 1ns/100ps

`include "norm_round_config.svh"

module fp_round
(
  input  norm_round_pkg::mant_norm_t   norm_mant,
  input  norm_round_pkg::round_ext_t   norm_ext,
  input  norm_round_pkg::exp_field_t   norm_exp,
  input  logic                         norm_sign,
  input  logic                         special_hit,
  input  norm_round_pkg::fp32_t        special_result,
  input  norm_round_pkg::fflags_t      pre_fflags,
  input  norm_round_pkg::round_mode_e  rm,
  output norm_round_pkg::fp32_t        result,
  output norm_round_pkg::fflags_t      fflags
);
  import norm_round_pkg::*;

  localparam int UPW = `NR_MANT_W + 2;  // Mantissa plus carry

  logic guard;
  logic sticky;
  logic inexact;
  logic round_up;
  logic carry;
  logic ovf;
  logic [UPW-1:0]        m_up;
  logic [`NR_MANT_W-1:0] frac_r;
  exp_field_t            exp_r;

  assign {guard, sticky} = norm_ext;
  assign inexact = guard | sticky;

  always_comb
  begin
    round_up = 1'b0;
    case (rm)
      RM_NEAREST:  round_up = guard & (sticky | norm_mant[0]);  // Ties go to even
      RM_TRUNC:    round_up = 1'b0;
      RM_PLUSINF:  round_up = inexact & ~norm_sign;
      RM_MINUSINF: round_up = inexact & norm_sign;
      default:     round_up = 1'b0;
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // Round, renormalize, overflow
  //////////////////////////////////////////////////////////////////////

  assign m_up   = {1'b0, norm_mant} + UPW'(round_up);
  assign carry  = m_up[UPW-1];                                 // 1.11..1 rolled over
  assign frac_r = carry ? m_up[`NR_MANT_W:1] : m_up[`NR_MANT_W-1:0];

  // A denormal that reaches the hidden bit becomes the smallest normal
  assign exp_r = (norm_exp == '0) ? exp_field_t'(m_up[`NR_MANT_W])
                                  : norm_exp + exp_field_t'(carry);
  assign ovf   = (exp_r == '1);

  always_comb
  begin
    fflags = '0;
    if (special_hit)
    begin
      result = special_result;
      fflags = pre_fflags;
    end
    else
    begin
      result = ovf ? {norm_sign, exp_r, {`NR_MANT_W{1'b0}}}   // Infinity
                   : {norm_sign, exp_r, frac_r};
      fflags[FL_OF] = ovf;
      fflags[FL_UF] = inexact & (norm_exp == '0);  // Tiny before rounding
      fflags[FL_NX] = inexact;
    end
  end

endmodule

// File: norm_round_lane.sv
// Two-cycle lane
// Normalizes into registers on the start cycle, rounds in the next one
// and holds the result while done is raised

`timescale 1ns/100ps

module norm_round_lane
(
  input  logic                         clk,
  input  logic                         reset,
  input  logic                         start,
  input  norm_round_pkg::mant_in_t     op_mant,
  input  norm_round_pkg::exp_in_t      op_exp,
  input  logic                         op_sign,
  input  norm_round_pkg::op_kind_e     op_kind,
  input  logic [6:0]                   op_special,
  input  norm_round_pkg::round_mode_e  op_rm,
  output logic                         done,
  output norm_round_pkg::fp32_t        lane_result,
  output norm_round_pkg::fflags_t      lane_fflags
);
  import norm_round_pkg::*;

  lane_state_e state;
  mant_norm_t  n_mant, n_mant_q;
  round_ext_t  n_ext, n_ext_q;
  exp_field_t  n_exp, n_exp_q;
  logic        n_sign, n_sign_q;
  logic        n_hit, n_hit_q;
  fp32_t       n_special, n_special_q;
  fflags_t     n_flags, n_flags_q;
  round_mode_e rm_q;
  fp32_t       r_result;
  fflags_t     r_fflags;

  fp_normalize u_normalize
  (
    .op_mant        (op_mant),
    .op_exp         (op_exp),
    .op_sign        (op_sign),
    .op_kind        (op_kind),
    .op_special     (op_special),
    .norm_mant      (n_mant),
    .norm_ext       (n_ext),
    .norm_exp       (n_exp),
    .norm_sign      (n_sign),
    .special_hit    (n_hit),
    .special_result (n_special),
    .pre_fflags     (n_flags)
  );

  // Stage between the two steps
  always_ff @(posedge clk)
  begin
    if (start)
    begin
      n_mant_q    <= n_mant;
      n_ext_q     <= n_ext;
      n_exp_q     <= n_exp;
      n_sign_q    <= n_sign;
      n_hit_q     <= n_hit;
      n_special_q <= n_special;
      n_flags_q   <= n_flags;
      rm_q        <= op_rm;
    end
    if (state == ST_NORM)
    begin
      lane_result <= r_result;
      lane_fflags <= r_fflags;
    end
  end

  fp_round u_round
  (
    .norm_mant      (n_mant_q),
    .norm_ext       (n_ext_q),
    .norm_exp       (n_exp_q),
    .norm_sign      (n_sign_q),
    .special_hit    (n_hit_q),
    .special_result (n_special_q),
    .pre_fflags     (n_flags_q),
    .rm             (rm_q),
    .result         (r_result),
    .fflags         (r_fflags)
  );

  // Busy FSM; a new start is legal again once the result is held
  always_ff @(posedge clk)
  begin
    if (reset)
      state <= ST_IDLE;
    else
    begin
      case (state)
        ST_IDLE:  state <= start ? ST_NORM : ST_IDLE;
        ST_NORM:  state <= ST_ROUND;
        ST_ROUND: state <= start ? ST_NORM : ST_IDLE;
        default:  state <= ST_IDLE;
      endcase
    end
  end

  assign done = (state == ST_ROUND);  // One cycle per operation

  // Round-robin spacing upstream keeps a lane from being restarted mid-op
  a_start_idle: assert property (@(posedge clk) disable iff (reset)
    start |-> state != ST_NORM)
    else $error("lane started while busy");

endmodule

// File: norm_round_collect.sv
// Result collector
// Takes lane results in dispatch order into the result FIFO, returns an
// upstream credit per pop and sends only while a downstream credit is held

`timescale 1ns/100ps

`include "norm_round_config.svh"

module norm_round_collect
(
  input  logic                     clk,
  input  logic                     reset,
  input  logic [`NR_LANES-1:0]     lane_done,
  input  norm_round_pkg::fp32_t    lane_result [`NR_LANES],
  input  norm_round_pkg::fflags_t  lane_fflags [`NR_LANES],
  input  logic                     out_credit,
  output logic                     out_valid,
  output norm_round_pkg::fp32_t    result,
  output norm_round_pkg::fflags_t  fflags,
  output logic                     in_credit
);
  import norm_round_pkg::*;

  localparam int LANES = `NR_LANES;
  localparam int DEPTH = `NR_IN_CREDITS;  // Power of two, pointers wrap
  localparam int AW    = $clog2(DEPTH);
  localparam int CW    = AW + 1;
  localparam int OCW   = $clog2(`NR_OUT_CREDITS + 1);

  lane_idx_t          rd_lane;    // Lane expected to finish next
  logic [LANES-1:0]   turn_mask;
  logic               wr;
  logic               rd;
  fp32_t              res_mem [DEPTH];
  fflags_t            flg_mem [DEPTH];
  logic [AW-1:0]      wr_ptr;
  logic [AW-1:0]      rd_ptr;
  logic [CW-1:0]      count;
  logic [OCW-1:0]     out_credits;

  assign turn_mask = LANES'(1) << rd_lane;
  assign wr        = |(lane_done & turn_mask);

  //////////////////////////////////////////////////////////////////////
  // Result FIFO
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk)
  begin
    if (wr)
    begin
      res_mem[wr_ptr] <= lane_result[rd_lane];
      flg_mem[wr_ptr] <= lane_fflags[rd_lane];
    end
  end

  assign out_valid = (count != '0) && (out_credits != '0);
  assign rd        = out_valid;          // Downstream takes every send
  assign result    = res_mem[rd_ptr];
  assign fflags    = flg_mem[rd_ptr];

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      rd_lane     <= '0;
      wr_ptr      <= '0;
      rd_ptr      <= '0;
      count       <= '0;
      out_credits <= OCW'(`NR_OUT_CREDITS);
      in_credit   <= 1'b0;
    end
    else
    begin
      if (wr)
      begin
        rd_lane <= (rd_lane == lane_idx_t'(LANES - 1)) ? '0 : rd_lane + 1'b1;
        wr_ptr  <= wr_ptr + 1'b1;
      end
      if (rd)
        rd_ptr <= rd_ptr + 1'b1;
      count       <= count + CW'(wr) - CW'(rd);
      out_credits <= out_credits - OCW'(rd) + OCW'(out_credit);
      in_credit   <= rd;                 // Slot freed, upstream may send again
    end
  end

  // Upstream credits bound the FIFO fill
  a_fifo_no_overflow: assert property (@(posedge clk) disable iff (reset)
    wr |-> count != CW'(DEPTH))
    else $error("result FIFO written while full");

  // Lanes finish in the order the dispatcher started them
  a_lane_in_turn: assert property (@(posedge clk) disable iff (reset)
    (lane_done & ~turn_mask) == '0)
    else $error("lane finished out of turn");

endmodule

// File: norm_round_top.sv
// FP32 normalize and round unit, top level
// Dispatcher, a row of identical two-cycle lanes and the in-order
// collector, with credit flow control on both sides

`timescale 1ns/100ps

`include "norm_round_config.svh"

module norm_round_top
(
  input  logic                         clk,
  input  logic                         reset,
  input  logic                         in_valid,
  input  norm_round_pkg::mant_in_t     mant_in,
  input  norm_round_pkg::exp_in_t      exp_in,
  input  logic                         sign_in,
  input  norm_round_pkg::op_kind_e     op,
  input  logic                         inf_a,
  input  logic                         inf_b,
  input  logic                         zero_a,
  input  logic                         zero_b,
  input  logic                         nan_a,
  input  logic                         nan_b,
  input  logic                         snan,
  input  norm_round_pkg::round_mode_e  rm,
  output logic                         in_credit,
  output logic                         out_valid,
  output norm_round_pkg::fp32_t        result,
  output norm_round_pkg::fflags_t      fflags,
  input  logic                         out_credit
);
  import norm_round_pkg::*;

  logic [`NR_LANES-1:0] lane_start;
  logic [`NR_LANES-1:0] lane_done;
  fp32_t       lane_result [`NR_LANES];
  fflags_t     lane_fflags [`NR_LANES];
  mant_in_t    op_mant;      // Registered operation, fanned out to every lane
  exp_in_t     op_exp;
  logic        op_sign;
  op_kind_e    op_kind;
  logic [6:0]  op_special;
  round_mode_e op_rm;

  norm_round_dispatch u_dispatch
  (
    .clk, .reset, .in_valid, .mant_in, .exp_in, .sign_in, .op,
    .inf_a, .inf_b, .zero_a, .zero_b, .nan_a, .nan_b, .snan, .rm, .in_credit,
    .lane_start, .op_mant, .op_exp, .op_sign, .op_kind, .op_special, .op_rm
  );

  for (genvar i = 0; i < `NR_LANES; i++)
  begin : g_lane
    norm_round_lane u_lane
    (
      .clk, .reset,
      .start       (lane_start[i]),
      .op_mant, .op_exp, .op_sign, .op_kind, .op_special, .op_rm,
      .done        (lane_done[i]),
      .lane_result (lane_result[i]),
      .lane_fflags (lane_fflags[i])
    );
  end

  norm_round_collect u_collect
  (
    .clk, .reset, .lane_done, .lane_result, .lane_fflags, .out_credit,
    .out_valid, .result, .fflags, .in_credit
  );

endmodule

// File: norm_round_model.svh
// Reference model of the FP32 normalize and round rules
// Special cases in priority order, then normalization, denormal shift,
// rounding and the {NV, DZ, OF, UF, NX} flags

`ifndef NORM_ROUND_MODEL_SVH
`define NORM_ROUND_MODEL_SVH

function automatic void model_norm_round
(
  input  logic [27:0]       mant,      // Weight 1 at the MSB
  input  logic signed [9:0] bexp,      // Biased, may be negative
  input  logic              sign,
  input  logic              is_sqrt,
  input  logic [6:0]        special,   // {inf_a, inf_b, zero_a, zero_b, nan_a, nan_b, snan}
  input  logic [1:0]        rmode,
  output logic [31:0]       res,
  output logic [4:0]        flg
);
  logic [31:0]  inf_r;
  logic [31:0]  zero_r;
  logic         ia, ib, za, zb, na, nb, sn;
  logic         is_div;
  logic [27:0]  m;
  int           e;
  int           ef;
  int           sh;
  logic [127:0] w;                     // Wide enough to lose no bit
  logic [24:0]  mr;
  logic         guard, sticky, inexact, tiny, up;
  {ia, ib, za, zb, na, nb, sn} = special;
  is_div = !is_sqrt;
  inf_r  = {sign, 8'hff, 23'h0};
  zero_r = {sign, 31'h0};
  res    = 32'h7fc0_0000;              // Quiet NaN unless a rule says otherwise
  flg    = 5'b00000;

  //////////////////////////////////////////////////////////////////////
  // Special cases
  //////////////////////////////////////////////////////////////////////
  if (na || nb)
  begin
    flg[4] = sn;                       // NV only for a signalling NaN
    return;
  end
  if (ia)
  begin
    if ((is_div && ib) || (is_sqrt && sign))
      flg[4] = 1'b1;
    else
      res = inf_r;
    return;
  end
  if (is_div && ib)
  begin
    res = zero_r;
    return;
  end
  if (za)
  begin
    if (is_div && zb)
      flg[4] = 1'b1;                   // 0/0
    else
      res = zero_r;
    return;
  end
  if (is_div && zb)
  begin
    res    = inf_r;
    flg[3] = 1'b1;                     // DZ
    return;
  end
  if (is_sqrt && sign)
  begin
    flg[4] = 1'b1;
    return;
  end
  if (mant == '0)
  begin
    res = zero_r;
    return;
  end

  //////////////////////////////////////////////////////////////////////
  // Normalize, denormalize, round
  //////////////////////////////////////////////////////////////////////
  m = mant;
  e = int'(bexp);
  if (!m[27])
  begin
    m = m << 1;                        // 0.1xx to 1.xx
    e = e - 1;
  end
  if (e >= 255)
  begin
    res = inf_r;
    flg = 5'b00101;                    // OF and NX
    return;
  end
  ef = e;
  sh = 0;
  if (e <= 0)
  begin
    sh = 1 - e;
    ef = 0;
  end
  w      = {m, 100'b0} >> sh;
  mr     = {1'b0, w[127:104]};
  guard  = w[103];
  sticky = |w[102:0];
  if (sh > 25)
  begin
    mr     = '0;                       // All bits below guard position
    guard  = 1'b0;
    sticky = 1'b1;
  end
  inexact = guard | sticky;
  tiny    = (ef == 0);
  case (rmode)
    2'd0:    up = guard & (sticky | mr[0]);
    2'd2:    up = inexact & !sign;
    2'd3:    up = inexact & sign;
    default: up = 1'b0;                // Truncate
  endcase
  mr = mr + 25'(up);
  if (mr[24])
  begin
    mr = mr >> 1;                      // Carry out, renormalize
    ef = ef + 1;
  end
  else if (tiny && mr[23])
    ef = 1;                            // Denormal rounded into smallest normal
  flg[1] = inexact & tiny;
  flg[0] = inexact;
  if (ef >= 255)
  begin
    res    = inf_r;
    flg[2] = 1'b1;
  end
  else
    res = {sign, ef[7:0], mr[22:0]};
endfunction

`endif

// File: norm_round_tb.sv
// Testbench for the FP32 normalize and round unit
// Random operations under credit flow control on both sides,
// results checked in arrival order against the reference model

`timescale 1ns/100ps

`include "norm_round_config.svh"

module norm_round_tb;
  import norm_round_pkg::*;

  localparam int NUM_OPS        = 2000;
  localparam int TIMEOUT_CYCLES = NUM_OPS * 8;

  logic        clk;
  logic        reset;
  logic        in_valid;
  mant_in_t    mant_in;
  exp_in_t     exp_in;
  logic        sign_in;
  op_kind_e    op;
  logic        inf_a, inf_b, zero_a, zero_b, nan_a, nan_b, snan;
  round_mode_e rm;
  logic        in_credit;
  logic        out_valid;
  fp32_t       result;
  fflags_t     fflags;
  logic        out_credit;

  integer  seed;
  int      in_credits;                 // Upstream credits we hold
  int      ds_credits;                 // Downstream credits the DUT holds
  int      sent;
  int      received;
  int      cycles = 0;
  logic    credit_back;
  fp32_t   exp_res_q[$];
  fflags_t exp_flg_q[$];

  `include "norm_round_model.svh"

  norm_round_top DUT
  (
    .clk, .reset, .in_valid, .mant_in, .exp_in, .sign_in, .op,
    .inf_a, .inf_b, .zero_a, .zero_b, .nan_a, .nan_b, .snan, .rm,
    .in_credit, .out_valid, .result, .fflags, .out_credit
  );

  initial clk = 1'b0;
  always #20 clk = ~clk;               // 40 ns period

  task automatic abort_run;
    $display("Test FAILED");
    $fatal(1, "Run stopped at the first error");
  endtask

  function automatic int rand_below(int n);
    rand_below = int'(($random(seed) & 32'h7fff_ffff) % n);
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////////////////////////

  task automatic make_operation;
    int      cat;
    int      e;
    fp32_t   want_res;
    fflags_t want_flg;
    cat     = rand_below(100);
    mant_in = mant_in_t'($random(seed));
    mant_in[27] = rand_below(2) == 0;
    mant_in[26] = 1'b1;                // Keeps the value in [0.5, 2)
    case (rand_below(8))
      0:
      begin
        if (mant_in[27])               // Exact tie after normalization
          mant_in[3:0] = 4'b1000;
        else
          mant_in[2:0] = 3'b100;
      end
      1: mant_in[3:0] = 4'b0000;       // Exact
      2: mant_in = 28'hfff_ffff;       // Carry out of rounding
      default: ;
    endcase
    if (rand_below(50) == 0)
      mant_in = '0;
    if (cat < 55)
      e = 1 + rand_below(254);
    else if (cat < 68)
      e = 240 + rand_below(61);        // Toward overflow
    else
      e = -40 + rand_below(51);        // Toward denormals
    if (cat >= 82)
      e = -40 + rand_below(341);
    exp_in  = exp_in_t'(e);
    {inf_a, inf_b, zero_a, zero_b, nan_a, nan_b, snan} =
      (cat >= 82) ? 7'($random(seed) & $random(seed)) : 7'b0;
    sign_in = 1'(rand_below(2));
    op      = op_kind_e'(1'(rand_below(2)));
    rm      = round_mode_e'(2'(rand_below(4)));
    model_norm_round(mant_in, exp_in, sign_in, op == OP_SQRT,
                     {inf_a, inf_b, zero_a, zero_b, nan_a, nan_b, snan}, rm,
                     want_res, want_flg);
    exp_res_q.push_back(want_res);
    exp_flg_q.push_back(want_flg);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Result checks
  //////////////////////////////////////////////////////////////////////

  task automatic check_output;
    fp32_t   want_res;
    fflags_t want_flg;
    if (out_valid)
    begin
      assert (ds_credits > 0)
      else
      begin
        $display("out_valid at %0t while the DUT held no downstream credit", $time);
        abort_run();
      end
      assert (exp_res_q.size() != 0)
      else
      begin
        $display("out_valid at %0t with no operation outstanding", $time);
        abort_run();
      end
      ds_credits--;
      want_res = exp_res_q.pop_front();
      want_flg = exp_flg_q.pop_front();
      assert (result === want_res)
      else
      begin
        $display("[FAIL] %0t ns: result = %h, expected %h", $time, result, want_res);
        abort_run();
      end
      assert (fflags === want_flg)
      else
      begin
        $display("[FAIL] %0t ns: fflags = %b, expected %b", $time, fflags, want_flg);
        abort_run();
      end
      received++;
    end
  endtask

  // Run limit
  always @(posedge clk)
  begin
    cycles = cycles + 1;
    if (cycles >= TIMEOUT_CYCLES)
    begin
      $display("Timeout after %0d cycles, %0d of %0d results received",
               cycles, received, NUM_OPS);
      abort_run();
    end
  end

  initial
  begin
    seed       = 32'h4b1a;
    reset      = 1'b1;
    in_valid   = 1'b0;
    mant_in    = '0;
    exp_in     = '0;
    sign_in    = 1'b0;
    op         = OP_DIV;
    {inf_a, inf_b, zero_a, zero_b, nan_a, nan_b, snan} = 7'b0;
    rm         = RM_NEAREST;
    out_credit = 1'b0;
    in_credits = `NR_IN_CREDITS;
    ds_credits = `NR_OUT_CREDITS;
    sent       = 0;
    received   = 0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    // Runs until every operation is sent and every upstream credit is back
    while (sent < NUM_OPS || in_credits != `NR_IN_CREDITS)
    begin
      @(negedge clk);
      check_output();
      credit_back = in_credit;
      in_valid    = 1'b0;
      if (sent < NUM_OPS && in_credits > 0 && rand_below(4) != 0)
      begin
        make_operation();
        in_valid = 1'b1;
        in_credits--;
        sent++;
      end
      if (credit_back)
        in_credits++;                  // Usable from the next cycle on
      assert (in_credits >= 0 && in_credits <= `NR_IN_CREDITS)
      else
      begin
        $display("Upstream credit count out of range at %0t: %0d", $time, in_credits);
        abort_run();
      end
      out_credit = 1'b0;               // Downstream frees a slot at random
      if (ds_credits < `NR_OUT_CREDITS && rand_below(2) == 0)
      begin
        out_credit = 1'b1;
        ds_credits++;
      end
    end

    in_valid   = 1'b0;
    out_credit = 1'b0;
    repeat (4)                         // Drained unit stays quiet
    begin
      @(negedge clk);
      assert (!out_valid)
      else
      begin
        $display("out_valid at %0t after every result had been received", $time);
        abort_run();
      end
    end
    assert (received == NUM_OPS && exp_res_q.size() == 0)
    else
    begin
      $display("Sent %0d operations but received %0d results", sent, received);
      abort_run();
    end
    $display("Test OK");
    $finish;
  end

endmodule

// File: norm_round_top.f
+incdir+.
norm_round_pkg.sv
norm_round_dispatch.sv
fp_normalize.sv
fp_round.sv
norm_round_lane.sv
norm_round_collect.sv
norm_round_top.sv
norm_round_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the normalize and round testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module norm_round_tb \
  -f norm_round_top.f > build.log 2>&1 \
  || { cat build.log; echo "Verilator build failed"; exit 1; }

./obj_dir/Vnorm_round_tb > sim.log 2>&1 || true
cat sim.log

grep -q "Test FAILED" sim.log && { echo "Simulation failed"; exit 1; }
grep -q "Test OK" sim.log || { echo "Simulation ended without a verdict"; exit 1; }
echo "Simulation passed"
